/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP        = tb_rv_core
FILELIST   = sources.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* rtl/rv_cfg.svh */
// core-wide widths, reset pc and rv32i opcodes, include wherever these constants are needed
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// datapath and register file sizing
`define RV_XLEN      32
`define RV_NREGS     32

// first fetch address after reset
`define RV_RESET_PC  32'h0000_0000

// rv32i base opcodes, instr[6:0]
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_ALUI   7'b0010011   // register-immediate alu ops
`define RV_OP_ALUR   7'b0110011   // register-register alu ops

`endif

/* rtl/rv_core_top.sv */
// three-stage rv32i core top, connects the stages to external instruction and data memory
`default_nettype none

module rv_core_top (
   input  wire logic           clk_i,
   input  wire logic           t_intr,
   output rv_pkg::word_t       imem_addr_o,
   input  rv_pkg::word_t       imem_rdata_i,
   output rv_pkg::word_t       dmem_addr_o,
   output logic                dmem_we_o,
   output logic                dmem_re_o,
   output rv_pkg::byte_mask_t  dmem_be_o,
   output rv_pkg::word_t       dmem_wdata_o,
   input  rv_pkg::word_t       dmem_rdata_i
);

   import rv_pkg::*;

   fd_reg_t  fd;
   em_reg_t  em;
   logic     stall;
   logic     redirect;
   word_t    target;
   word_t    rs_a;
   word_t    rs_b;
   logic     rf_we;
   reg_idx_t rf_waddr;
   word_t    rf_wdata;

   rv_fetch u_fetch (
      .clk_i        (clk_i),
      .t_intr       (t_intr),
      .stall_i      (stall),
      .redirect_i   (redirect),
      .target_i     (target),
      .imem_addr_o  (imem_addr_o),
      .imem_rdata_i (imem_rdata_i),
      .fd_o         (fd)
   );

   // rs1/rs2 fields straight from the decode word
   rv_regfile u_regfile (
      .clk_i     (clk_i),
      .t_intr    (t_intr),
      .raddr_a_i (fd.instr[19:15]),
      .raddr_b_i (fd.instr[24:20]),
      .rdata_a_o (rs_a),
      .rdata_b_o (rs_b),
      .we_i      (rf_we),
      .waddr_i   (rf_waddr),
      .wdata_i   (rf_wdata)
   );

   rv_execute u_execute (
      .clk_i      (clk_i),
      .t_intr     (t_intr),
      .fd_i       (fd),
      .rs_a_i     (rs_a),
      .rs_b_i     (rs_b),
      .em_i       (em),      // fed back for forwarding and hazards
      .em_o       (em),
      .stall_o    (stall),
      .redirect_o (redirect),
      .target_o   (target)
   );

   rv_lsu u_lsu (
      .em_i         (em),
      .dmem_addr_o  (dmem_addr_o),
      .dmem_we_o    (dmem_we_o),
      .dmem_re_o    (dmem_re_o),
      .dmem_be_o    (dmem_be_o),
      .dmem_wdata_o (dmem_wdata_o),
      .dmem_rdata_i (dmem_rdata_i),
      .rf_we_o      (rf_we),
      .rf_waddr_o   (rf_waddr),
      .rf_wdata_o   (rf_wdata)
   );

endmodule

`default_nettype wire

/* rtl/rv_decoder.sv */
// combinational rv32i decoder for the decode/execute stage, used inside the execute stage
`default_nettype none

`include "rv_cfg.svh"

module rv_decoder (
   input  rv_pkg::word_t instr_i,
   output rv_pkg::ctrl_t ctrl_o,
   output rv_pkg::word_t imm_o
);

   import rv_pkg::*;

   logic [6:0] opcode;
   funct3_t    funct3;
   logic       f7b5;
   logic       is_alur;
   alu_op_e    alu_fn;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_u;
   word_t      imm_j;

   assign opcode  = instr_i[6:0];
   assign funct3  = instr_i[14:12];
   assign f7b5    = instr_i[30];
   assign is_alur = (opcode == `RV_OP_ALUR);

   // immediate formats
   assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
   assign imm_u = {instr_i[31:12], 12'b0};
   assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

   // alu op from funct3, bit 30 picks sub only for register form
   always_comb begin
      case (funct3)
         3'b000:  alu_fn = (is_alur && f7b5) ? alu_sub : alu_add;
         3'b001:  alu_fn = alu_sll;
         3'b010:  alu_fn = alu_slt;
         3'b011:  alu_fn = alu_sltu;
         3'b100:  alu_fn = alu_xor;
         3'b101:  alu_fn = f7b5 ? alu_sra : alu_srl;   // srai uses bit 30 too
         3'b110:  alu_fn = alu_or;
         default: alu_fn = alu_and;
      endcase
   end

   always_comb begin
      ctrl_o        = '0;   // unknown opcode falls through as a no-op
      ctrl_o.alu_op = alu_add;
      ctrl_o.wb_sel = wb_alu;
      imm_o         = imm_i;
      case (opcode)
         `RV_OP_LUI: begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.src_b_imm = 1'b1;
            ctrl_o.alu_op    = alu_pass_b;
            imm_o            = imm_u;
         end
         `RV_OP_AUIPC: begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.src_a_pc  = 1'b1;
            ctrl_o.src_b_imm = 1'b1;
            imm_o            = imm_u;
         end
         `RV_OP_JAL: begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.jump      = 1'b1;
            ctrl_o.wb_sel    = wb_pc4;
            imm_o            = imm_j;
         end
         `RV_OP_JALR: begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.jump      = 1'b1;
            ctrl_o.jump_reg  = 1'b1;
            ctrl_o.wb_sel    = wb_pc4;
         end
         `RV_OP_BRANCH: begin
            ctrl_o.branch = 1'b1;
            imm_o         = imm_b;
         end
         `RV_OP_LOAD: begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.mem_read  = 1'b1;
            ctrl_o.src_b_imm = 1'b1;
            ctrl_o.wb_sel    = wb_load;
         end
         `RV_OP_STORE: begin
            ctrl_o.mem_write = 1'b1;
            ctrl_o.src_b_imm = 1'b1;
            imm_o            = imm_s;
         end
         `RV_OP_ALUI: begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.src_b_imm = 1'b1;
            ctrl_o.alu_op    = alu_fn;
         end
         `RV_OP_ALUR: begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.alu_op    = alu_fn;
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/rv_execute.sv */
// decode/execute stage with forwarding, alu, branch resolve and load-use stall for the core top
`default_nettype none

module rv_execute (
   input  wire logic       clk_i,
   input  wire logic       t_intr,
   input  rv_pkg::fd_reg_t fd_i,
   input  rv_pkg::word_t   rs_a_i,
   input  rv_pkg::word_t   rs_b_i,
   input  rv_pkg::em_reg_t em_i,     // instruction now in memory/writeback
   output rv_pkg::em_reg_t em_o,
   output logic            stall_o,
   output logic            redirect_o,
   output rv_pkg::word_t   target_o
);

   import rv_pkg::*;

   ctrl_t    ctrl;
   word_t    imm;
   reg_idx_t rs1;
   reg_idx_t rs2;
   word_t    fwd_val;
   logic     fwd_ok;
   word_t    op_a;
   word_t    op_b;
   word_t    alu_a;
   word_t    alu_b;
   word_t    alu_res;
   word_t    jalr_sum;
   logic     br_cond;
   em_reg_t  em_q;

   rv_decoder u_decoder (
      .instr_i (fd_i.instr),
      .ctrl_o  (ctrl),
      .imm_o   (imm)
   );

   assign rs1 = fd_i.instr[19:15];
   assign rs2 = fd_i.instr[24:20];

   // loads are left to the stall and links forward pc+4
   assign fwd_ok  = em_i.valid && em_i.reg_write && (em_i.wb_sel != wb_load) && (em_i.rd != '0);
   assign fwd_val = (em_i.wb_sel == wb_pc4) ? em_i.pc_plus_4 : em_i.alu_result;
   assign op_a    = (fwd_ok && em_i.rd == rs1) ? fwd_val : rs_a_i;
   assign op_b    = (fwd_ok && em_i.rd == rs2) ? fwd_val : rs_b_i;

   assign alu_a = ctrl.src_a_pc ? fd_i.pc : op_a;
   assign alu_b = ctrl.src_b_imm ? imm : op_b;

   always_comb begin
      case (ctrl.alu_op)
         alu_sub:  alu_res = alu_a - alu_b;
         alu_sll:  alu_res = alu_a << alu_b[4:0];
         alu_slt:  alu_res = word_t'($signed(alu_a) < $signed(alu_b));
         alu_sltu: alu_res = word_t'(alu_a < alu_b);
         alu_xor:  alu_res = alu_a ^ alu_b;
         alu_srl:  alu_res = alu_a >> alu_b[4:0];
         alu_sra:  alu_res = word_t'($signed(alu_a) >>> alu_b[4:0]);
         alu_or:   alu_res = alu_a | alu_b;
         alu_and:  alu_res = alu_a & alu_b;
         alu_pass_b: alu_res = alu_b;
         default:  alu_res = alu_a + alu_b;
      endcase
   end

   always_comb begin
      case (fd_i.instr[14:12])
         3'b000:  br_cond = (op_a == op_b);
         3'b001:  br_cond = (op_a != op_b);
         3'b100:  br_cond = ($signed(op_a) < $signed(op_b));
         3'b101:  br_cond = ($signed(op_a) >= $signed(op_b));
         3'b110:  br_cond = (op_a < op_b);
         3'b111:  br_cond = (op_a >= op_b);
         default: br_cond = 1'b0;
      endcase
   end

   // load data comes too late to forward so decode waits a cycle
   assign stall_o = em_i.valid && em_i.mem_read && (em_i.rd != '0)
                    && (em_i.rd == rs1 || em_i.rd == rs2);

   assign redirect_o = !stall_o && (ctrl.jump || (ctrl.branch && br_cond));

   assign jalr_sum = op_a + imm;
   assign target_o = ctrl.jump_reg ? {jalr_sum[$bits(word_t)-1:1], 1'b0} : fd_i.pc + imm;

   always_ff @(posedge clk_i or posedge t_intr) begin
      if (t_intr) begin
         em_q <= '0;
      end else if (stall_o || !fd_i.valid) begin
         em_q <= '0;   // bubble
      end else begin
         em_q.valid      <= 1'b1;
         em_q.reg_write  <= ctrl.reg_write;
         em_q.mem_write  <= ctrl.mem_write;
         em_q.mem_read   <= ctrl.mem_read;
         em_q.wb_sel     <= ctrl.wb_sel;
         em_q.funct3     <= fd_i.instr[14:12];
         em_q.rd         <= fd_i.instr[11:7];
         em_q.alu_result <= alu_res;
         em_q.store_data <= op_b;
         em_q.pc_plus_4  <= fd_i.pc + 32'd4;
      end
   end

   assign em_o = em_q;

   // a squashed fd holds an all-zero word that decodes to no control
   a_no_ctrl_on_bubble : assert property (@(posedge clk_i) disable iff (t_intr)
      !fd_i.valid |-> !(redirect_o || stall_o));

   // decoder and pipeline register agree that stores never write back
   a_store_no_wb : assert property (@(posedge clk_i) disable iff (t_intr)
      em_o.valid |-> !(em_o.mem_write && em_o.reg_write));

endmodule

`default_nettype wire

/* rtl/rv_fetch.sv */
// fetch stage, owns the pc and the fetch-to-decode register, instantiated by the core top
`default_nettype none

`include "rv_cfg.svh"

module rv_fetch (
   input  wire logic            clk_i,
   input  wire logic            t_intr,
   input  wire logic            stall_i,
   input  wire logic            redirect_i,
   input  rv_pkg::word_t        target_i,
   output rv_pkg::word_t        imem_addr_o,
   input  rv_pkg::word_t        imem_rdata_i,
   output rv_pkg::fd_reg_t      fd_o
);

   import rv_pkg::*;

   word_t   pc_q;
   word_t   pc_next;
   fd_reg_t fd_q;

   // redirect wins, a stalled branch never redirects
   always_comb begin
      if (redirect_i) begin
         pc_next = target_i;
      end else if (stall_i) begin
         pc_next = pc_q;   // load-use hold
      end else begin
         pc_next = pc_q + 32'd4;
      end
   end

   always_ff @(posedge clk_i or posedge t_intr) begin
      if (t_intr) begin
         pc_q <= `RV_RESET_PC;
      end else begin
         pc_q <= pc_next;
      end
   end

   always_ff @(posedge clk_i or posedge t_intr) begin
      if (t_intr) begin
         fd_q <= '0;
      end else if (redirect_i) begin
         fd_q <= '0;                   // squash the wrong-path fetch
      end else if (!stall_i) begin
         fd_q <= '{valid: 1'b1, instr: imem_rdata_i, pc: pc_q};
      end
   end

   assign imem_addr_o = pc_q;
   assign fd_o        = fd_q;

endmodule

`default_nettype wire

/* rtl/rv_lsu.sv */
// memory/writeback stage, drives the data memory port and the register file write
`default_nettype none

module rv_lsu (
   input  rv_pkg::em_reg_t    em_i,
   output rv_pkg::word_t      dmem_addr_o,
   output logic               dmem_we_o,
   output logic               dmem_re_o,
   output rv_pkg::byte_mask_t dmem_be_o,
   output rv_pkg::word_t      dmem_wdata_o,
   input  rv_pkg::word_t      dmem_rdata_i,
   output logic               rf_we_o,
   output rv_pkg::reg_idx_t   rf_waddr_o,
   output rv_pkg::word_t      rf_wdata_o
);

   import rv_pkg::*;

   logic [1:0] offs;      // byte offset in the word
   byte_mask_t st_mask;
   word_t      shifted;
   word_t      load_val;

   assign offs        = em_i.alu_result[1:0];
   assign dmem_addr_o = {em_i.alu_result[$bits(word_t)-1:2], 2'b00};
   assign dmem_we_o   = em_i.valid && em_i.mem_write;
   assign dmem_re_o   = em_i.valid && em_i.mem_read;

   // replicate store data, mask picks the lanes
   always_comb begin
      case (em_i.funct3[1:0])
         2'b00: begin
            dmem_wdata_o = {4{em_i.store_data[7:0]}};
            st_mask      = 4'b0001 << offs;
         end
         2'b01: begin
            dmem_wdata_o = {2{em_i.store_data[15:0]}};
            st_mask      = 4'b0011 << {offs[1], 1'b0};
         end
         default: begin
            dmem_wdata_o = em_i.store_data;
            st_mask      = 4'b1111;
         end
      endcase
   end

   assign dmem_be_o = dmem_we_o ? st_mask : '0;

   assign shifted = dmem_rdata_i >> {offs, 3'b000};

   always_comb begin
      case (em_i.funct3)
         3'b000:  load_val = {{24{shifted[7]}}, shifted[7:0]};     // lb
         3'b001:  load_val = {{16{shifted[15]}}, shifted[15:0]};   // lh
         3'b100:  load_val = {24'b0, shifted[7:0]};                // lbu
         3'b101:  load_val = {16'b0, shifted[15:0]};               // lhu
         default: load_val = dmem_rdata_i;
      endcase
   end

   assign rf_we_o    = em_i.valid && em_i.reg_write;
   assign rf_waddr_o = em_i.rd;

   always_comb begin
      case (em_i.wb_sel)
         wb_load: rf_wdata_o = load_val;
         wb_pc4:  rf_wdata_o = em_i.pc_plus_4;   // jal/jalr link
         default: rf_wdata_o = em_i.alu_result;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/rv_pkg.sv */
// shared types of the three-stage core, compile before every rtl module
`default_nettype none

`include "rv_cfg.svh"

package rv_pkg;

   typedef logic [`RV_XLEN-1:0]          word_t;
   typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;
   typedef logic [2:0]                   funct3_t;
   typedef logic [`RV_XLEN/8-1:0]        byte_mask_t;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
      alu_srl, alu_sra, alu_or, alu_and, alu_pass_b   // pass_b for lui
   } alu_op_e;

   typedef enum logic [1:0] {
      wb_alu, wb_load, wb_pc4
   } wb_sel_e;

   // fetch to decode/execute
   typedef struct packed {
      logic  valid;
      word_t instr;
      word_t pc;
   } fd_reg_t;

   typedef struct packed {
      logic    reg_write;
      logic    mem_write;
      logic    mem_read;
      logic    branch;
      logic    jump;
      logic    jump_reg;    // jalr, target from rs1
      logic    src_a_pc;
      logic    src_b_imm;
      alu_op_e alu_op;
      wb_sel_e wb_sel;
   } ctrl_t;

   // decode/execute to memory/writeback
   typedef struct packed {
      logic     valid;
      logic     reg_write;
      logic     mem_write;
      logic     mem_read;
      wb_sel_e  wb_sel;
      funct3_t  funct3;      // load/store size and sign
      reg_idx_t rd;
      word_t    alu_result;  // also the memory address
      word_t    store_data;
      word_t    pc_plus_4;
   } em_reg_t;

endpackage

`default_nettype wire

/* rtl/rv_regfile.sv */
// integer register file with write-through read ports, instantiated by the core top
`default_nettype none

`include "rv_cfg.svh"

module rv_regfile (
   input  wire logic       clk_i,
   input  wire logic       t_intr,
   input  rv_pkg::reg_idx_t raddr_a_i,
   input  rv_pkg::reg_idx_t raddr_b_i,
   output rv_pkg::word_t    rdata_a_o,
   output rv_pkg::word_t    rdata_b_o,
   input  wire logic       we_i,
   input  rv_pkg::reg_idx_t waddr_i,
   input  rv_pkg::word_t    wdata_i
);

   import rv_pkg::*;

   word_t regs [0:`RV_NREGS-1];
   logic  wr_live;   // a real write this cycle, x0 excluded

   assign wr_live = we_i && (waddr_i != '0);

   always_ff @(posedge clk_i or posedge t_intr) begin
      if (t_intr) begin
         for (int i = 0; i < `RV_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_live) begin
         regs[waddr_i] <= wdata_i;
      end
   end

   // writeback value seen by decode in the same cycle
   assign rdata_a_o = (wr_live && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
   assign rdata_b_o = (wr_live && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

   // x0 storage must never pick up a writeback
   a_x0_zero : assert property (@(posedge clk_i) disable iff (t_intr) regs[0] == '0);

endmodule

`default_nettype wire

/* sim/tb_rv_core.sv */
// top-level testbench for the rv32i core that models both memories and checks every store in order
`default_nettype none

`include "rv_cfg.svh"

module tb_rv_core;

   timeunit 1ns;
   timeprecision 1ps;

   import rv_pkg::*;

   localparam int    PROG_WORDS = 512;
   localparam int    DMEM_WORDS = 512;
   localparam int    MAX_STORES = 256;
   localparam int    WAIT_LIMIT = 200;
   localparam word_t NOP        = 32'h0000_0013;   // addi x0, x0, 0
   localparam word_t RES_BASE   = 32'h0000_0200;   // base of the result slots held in x1
   localparam word_t WORD_A     = 32'h8765_F0A1;   // word at 0x100 with negative lanes
   localparam word_t WORD_B     = 32'h1234_7F5E;   // word at 0x104 with positive lanes

   // funct3 and bit 30 of each tested op
   localparam logic [2:0] R_F3  [0:9] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                          3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
   localparam logic       R_ALT [0:9] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                          1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
   localparam logic [2:0] I_F3  [0:8] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
   localparam logic       I_ALT [0:8] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
   localparam logic [2:0] B_F3  [0:5] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
   localparam logic [2:0] L_F3  [0:3] = '{3'd0, 3'd1, 3'd4, 3'd5};   // lb lh lbu lhu

   logic       clk_i;
   logic       t_intr;
   word_t      imem_addr;
   word_t      imem_rdata;
   word_t      dmem_addr;
   logic       dmem_we;
   logic       dmem_re;
   byte_mask_t dmem_be;
   word_t      dmem_wdata;
   word_t      dmem_rdata;

   word_t      prog [0:PROG_WORDS-1];
   word_t      dmem [0:DMEM_WORDS-1];
   word_t      exp_addr [0:MAX_STORES-1];
   byte_mask_t exp_be [0:MAX_STORES-1];
   word_t      exp_data [0:MAX_STORES-1];
   int         prog_len;
   int         slot;
   int         n_exp;

   rv_core_top u_dut (
      .clk_i        (clk_i),
      .t_intr       (t_intr),
      .imem_addr_o  (imem_addr),
      .imem_rdata_i (imem_rdata),
      .dmem_addr_o  (dmem_addr),
      .dmem_we_o    (dmem_we),
      .dmem_re_o    (dmem_re),
      .dmem_be_o    (dmem_be),
      .dmem_wdata_o (dmem_wdata),
      .dmem_rdata_i (dmem_rdata)
   );

   always #50 clk_i = ~clk_i;

   assign imem_rdata = ((imem_addr >> 2) < word_t'(prog_len)) ? prog[imem_addr[10:2]] : NOP;
   assign dmem_rdata = dmem_re ? dmem[dmem_addr[10:2]] : 32'h0;

   function automatic word_t fill_word(int i);
      return {8'(i), ~8'(i), 8'(i >> 8) ^ 8'h5a, 8'hc3};
   endfunction

   // preload during reset and byte-lane writes after it
   always @(posedge clk_i or posedge t_intr) begin
      if (t_intr) begin
         for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= fill_word(i);
         end
         dmem[64] <= WORD_A;
         dmem[65] <= WORD_B;
      end else if (dmem_we) begin
         for (int l = 0; l < 4; l++) begin
            if (dmem_be[l]) begin
               dmem[dmem_addr[10:2]][8*l +: 8] <= dmem_wdata[8*l +: 8];
            end
         end
      end
   end

   function automatic word_t r_type(logic alt, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3, logic [4:0] rd);
      return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `RV_OP_ALUR};
   endfunction

   function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                    logic [4:0] rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
   endfunction

   function automatic word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
   endfunction

   function automatic word_t u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic word_t j_type(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
   endfunction

   // rv32i result of one alu op
   function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
      word_t r;
      case (f3)
         3'd0: r = alt ? a - b : a + b;
         3'd1: r = a << b[4:0];
         3'd2: r = word_t'($signed(a) < $signed(b));
         3'd3: r = word_t'(a < b);
         3'd4: r = a ^ b;
         3'd5: begin
            if (alt) begin
               r = $signed(a) >>> b[4:0];
            end else begin
               r = a >> b[4:0];
            end
         end
         3'd6: r = a | b;
         default: r = a & b;
      endcase
      return r;
   endfunction

   function automatic logic br_ref(logic [2:0] f3, word_t x, word_t y);
      case (f3)
         3'd0: return x == y;
         3'd1: return x != y;
         3'd4: return $signed(x) < $signed(y);
         3'd5: return $signed(x) >= $signed(y);
         3'd6: return x < y;
         default: return x >= y;
      endcase
   endfunction

   function automatic word_t load_ref(word_t w, logic [2:0] f3, int off);
      logic [7:0]  b;
      logic [15:0] h;
      b = w[8*off +: 8];
      h = (off == 0) ? w[15:0] : w[31:16];
      case (f3)
         3'd0: return {{24{b[7]}}, b};
         3'd1: return {{16{h[15]}}, h};
         3'd4: return {24'b0, b};
         default: return {16'b0, h};
      endcase
   endfunction

   function automatic word_t lane_bits(byte_mask_t be);
      word_t m;
      for (int l = 0; l < 4; l++) begin
         m[8*l +: 8] = {8{be[l]}};
      end
      return m;
   endfunction

   function automatic word_t pc_now();
      return word_t'(prog_len * 4);
   endfunction

   task automatic emit(word_t w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   task automatic load_const(logic [4:0] rd, word_t v);
      word_t up;
      up = v + 32'h800;   // addi sign-extends its low part
      emit(u_type(up[31:12], rd, `RV_OP_LUI));
      emit(i_type(v[11:0], rd, 3'd0, rd, `RV_OP_ALUI));
   endtask

   // store into the next result slot and expect it only when want is set
   task automatic store_to_slot(logic [2:0] f3, logic [4:0] rs, int off, byte_mask_t be,
                                word_t data, logic want);
      emit(s_type(12'(slot * 4 + off), rs, 5'd1, f3));
      if (want) begin
         exp_addr[n_exp] = RES_BASE + word_t'(slot * 4);
         exp_be[n_exp]   = be;
         exp_data[n_exp] = data;
         n_exp++;
      end
      slot++;
   endtask

   task automatic sw_slot(logic [4:0] rs, word_t data, logic want);
      store_to_slot(3'd2, rs, 0, 4'hF, data, want);
   endtask

   task automatic build_program();
      word_t       a;
      word_t       b;
      word_t       c;
      word_t       q;
      logic [11:0] imm;
      logic [4:0]  ra;
      logic [4:0]  rb;
      prog_len = 0;
      slot     = 0;
      n_exp    = 0;
      for (int i = 0; i < PROG_WORDS; i++) begin
         prog[i] = NOP;
      end
      emit(i_type(RES_BASE[11:0], 5'd0, 3'd0, 5'd1, `RV_OP_ALUI));
      for (int round = 0; round < 3; round++) begin
         a = $urandom();
         b = $urandom();
         load_const(5'd5, a);
         load_const(5'd6, b);
         for (int i = 0; i < 10; i++) begin
            emit(r_type(R_ALT[i], 5'd6, 5'd5, R_F3[i], 5'd7));
            sw_slot(5'd7, alu_ref(R_F3[i], R_ALT[i], a, b), 1'b1);   // data forwarded
         end
         for (int i = 0; i < 9; i++) begin
            imm = 12'($urandom());
            if (I_F3[i] == 3'd1 || I_F3[i] == 3'd5) begin
               imm = {1'b0, I_ALT[i], 5'b0, imm[4:0]};   // shamt form
            end
            emit(i_type(imm, 5'd5, I_F3[i], 5'd7, `RV_OP_ALUI));
            sw_slot(5'd7, alu_ref(I_F3[i], I_ALT[i], a, {{20{imm[11]}}, imm}), 1'b1);
         end
         q = $urandom();
         emit(u_type(q[31:12], 5'd7, `RV_OP_LUI));
         sw_slot(5'd7, {q[31:12], 12'b0}, 1'b1);
         c = pc_now();
         emit(u_type(q[31:12], 5'd7, `RV_OP_AUIPC));
         sw_slot(5'd7, c + {q[31:12], 12'b0}, 1'b1);
      end
      // dependent add chain
      c = $urandom();
      load_const(5'd9, c);
      emit(r_type(1'b0, 5'd9, 5'd0, 3'd0, 5'd10));
      for (int i = 0; i < 3; i++) begin
         emit(r_type(1'b0, 5'd9, 5'd10, 3'd0, 5'd10));
         emit(r_type(1'b0, 5'd9, 5'd10, 3'd0, 5'd10));
         sw_slot(5'd10, c * word_t'(3 + 2 * i), 1'b1);
      end
      // load-use followed by a store of the loaded value
      emit(i_type(12'h100, 5'd0, 3'd2, 5'd11, `RV_OP_LOAD));
      emit(r_type(1'b0, 5'd9, 5'd11, 3'd0, 5'd12));
      sw_slot(5'd12, WORD_A + c, 1'b1);
      emit(i_type(12'h104, 5'd0, 3'd2, 5'd11, `RV_OP_LOAD));
      sw_slot(5'd11, WORD_B, 1'b1);
      // branches on a negative and a positive operand
      a = $urandom() | 32'h8000_0000;
      b = $urandom() & 32'h7fff_ffff;
      load_const(5'd13, a);
      load_const(5'd14, b);
      emit(i_type(12'h015, 5'd0, 3'd0, 5'd15, `RV_OP_ALUI));
      emit(i_type(12'h016, 5'd0, 3'd0, 5'd16, `RV_OP_ALUI));
      for (int i = 0; i < 6; i++) begin
         for (int p = 0; p < 3; p++) begin
            ra = (p == 1) ? 5'd14 : 5'd13;
            rb = (p == 0) ? 5'd14 : 5'd13;
            emit(b_type(13'd8, rb, ra, B_F3[i]));
            sw_slot(5'd15, 32'h15, !br_ref(B_F3[i], (p == 1) ? b : a, (p == 0) ? b : a));
            sw_slot(5'd16, 32'h16, 1'b1);   // branch target
         end
      end
      c = pc_now();
      emit(j_type(21'd8, 5'd17));
      sw_slot(5'd15, 32'h15, 1'b0);
      sw_slot(5'd17, c + 32'd4, 1'b1);
      c = pc_now();
      emit(u_type(20'h0, 5'd18, `RV_OP_AUIPC));
      emit(i_type(12'd17, 5'd18, 3'd0, 5'd19, `RV_OP_JALR));   // odd offset so bit 0 is dropped
      sw_slot(5'd15, 32'h15, 1'b0);
      sw_slot(5'd15, 32'h15, 1'b0);
      sw_slot(5'd19, c + 32'd8, 1'b1);
      // sub-word stores with lane and mask set by the address
      q = $urandom();
      load_const(5'd20, q);
      for (int k = 0; k < 4; k++) begin
         store_to_slot(3'd0, 5'd20, k, byte_mask_t'(4'b0001 << k), {24'b0, q[7:0]} << (8 * k),
                       1'b1);
      end
      for (int k = 0; k < 4; k += 2) begin
         store_to_slot(3'd1, 5'd20, k, byte_mask_t'(4'b0011 << k), {16'b0, q[15:0]} << (8 * k),
                       1'b1);
      end
      for (int w = 0; w < 2; w++) begin
         for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 4; k += (L_F3[i][0] ? 2 : 1)) begin
               emit(i_type(12'(256 + 4 * w + k), 5'd0, L_F3[i], 5'd21, `RV_OP_LOAD));
               sw_slot(5'd21, load_ref((w == 0) ? WORD_A : WORD_B, L_F3[i], k), 1'b1);
            end
         end
      end
   endtask

   task automatic check_value(string what, word_t got, word_t exp);
      if (got !== exp) begin
         $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
         $display("*** FAILED ***");
         $fatal(1, "mismatch on %s", what);
      end
   endtask

   initial begin
      int waited;
      int extra;
      void'($urandom(32'h2ab5_0767));
      clk_i  = 1'b0;
      t_intr = 1'b1;
      build_program();
      repeat (4) @(posedge clk_i);
      #10;
      check_value("write strobe in reset", word_t'(dmem_we), 32'd0);
      check_value("read strobe in reset", word_t'(dmem_re), 32'd0);
      t_intr = 1'b0;
      for (int k = 0; k < n_exp; k++) begin
         waited = 0;
         @(negedge clk_i);
         while (!dmem_we) begin
            if (waited >= WAIT_LIMIT) begin
               $display("timeout: store %0d of %0d not seen within %0d cycles",
                        k, n_exp, WAIT_LIMIT);
               $display("*** FAILED ***");
               $fatal(1, "core stopped storing");
            end
            @(negedge clk_i);
            waited++;
         end
         check_value($sformatf("store %0d address", k), dmem_addr, exp_addr[k]);
         check_value($sformatf("store %0d byte mask", k), word_t'(dmem_be), word_t'(exp_be[k]));
         check_value($sformatf("store %0d data", k), dmem_wdata & lane_bits(exp_be[k]),
                     exp_data[k]);
         check_value($sformatf("store %0d read strobe", k), word_t'(dmem_re), 32'd0);
      end
      // program tail is nops only
      extra = 0;
      repeat (20) begin
         @(negedge clk_i);
         if (dmem_we) begin
            extra++;
         end
      end
      check_value("stores after the last expected one", word_t'(extra), 32'd0);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_lsu.sv
rtl/rv_core_top.sv
sim/tb_rv_core.sv
